//--- hdl/alu_pkg.sv
package alu_pkg;

	// Lane geometry
	localparam int num_lanes  = 4;
	localparam int lane_width = 32;

	typedef logic [lane_width-1:0]           lane_t;  // One 32-bit lane word
	typedef logic [num_lanes*lane_width-1:0] vec_t;   // Lane 0 in the low bits
	typedef logic [num_lanes-1:0]            flags_t; // One bit per lane

	// Shared by all lanes
	typedef enum logic [3:0] {
		op_fadd      = 4'd0,
		op_fmul      = 4'd1,
		op_fdiv_rsvd = 4'd2,  // No divider behind this code
		op_fsub      = 4'd3,
		op_or        = 4'd4,
		op_and       = 4'd5,
		op_xor       = 4'd6,
		op_shl       = 4'd7,
		op_shr       = 4'd8,
		op_ftrunc    = 4'd9,
		op_not       = 4'd10,
		op_iadd      = 4'd11,  // Carry out reported as overflow
		op_iabsdiff  = 4'd12,
		op_imul_hi   = 4'd13,
		op_imul_lo   = 4'd14,
		op_nop       = 4'd15
	} alu_op_e;

endpackage

//--- hdl/fp_pkg.sv
package fp_pkg;

	// IEEE-754 single layout
	localparam int exp_width   = 8;
	localparam int frac_width  = 23;
	localparam int sig_width   = frac_width + 1;  // Hidden bit on top
	localparam int fp_sign_pos = 31;

	// Exponent values, sized to the field
	localparam logic [exp_width-1:0] exp_bias = 8'd127;
	localparam logic [exp_width-1:0] exp_max  = 8'd255;  // Inf and NaN

endpackage

//--- hdl/fp_norm.sv
module fp_norm (
	input  logic [fp_pkg::sig_width:0]   sig,     // Bit 24 is the carry position
	input  logic [fp_pkg::exp_width-1:0] exp_in,
	output logic [fp_pkg::sig_width:0]   sig_out,
	output logic [fp_pkg::exp_width-1:0] exp_out
);

	localparam int sw      = fp_pkg::sig_width;
	localparam int shift_w = $clog2(sw);  // Counts 0 to 23

	logic [shift_w-1:0] lead_shift;
	logic               is_zero;

	// Leading one search below the carry bit
	always_comb
	begin
		lead_shift = '0;
		for (int i = 0; i < sw; i++)
		begin
			if (sig[i])
				lead_shift = shift_w'(sw - 1 - i);  // Highest set bit wins
		end
	end

	assign is_zero = ~|sig[sw-1:0];  // Equal magnitudes

	// Left normalize, exponent follows
	always_comb
	begin
		if (is_zero)
		begin
			sig_out = '0;
			exp_out = '0;
		end
		else
		begin
			sig_out = sig << lead_shift;
			exp_out = exp_in - {{(fp_pkg::exp_width-shift_w){1'b0}}, lead_shift};
		end
	end

endmodule

//--- hdl/fp_add_sub.sv
module fp_add_sub (
	input  alu_pkg::lane_t a,
	input  alu_pkg::lane_t b,
	input  logic           sub,
	output alu_pkg::lane_t y,
	output logic           exception
);

	localparam int sp = fp_pkg::fp_sign_pos;
	localparam int ew = fp_pkg::exp_width;
	localparam int fw = fp_pkg::frac_width;
	localparam int sw = fp_pkg::sig_width;
	localparam logic [ew-1:0] exp_one = 1;

	logic           swap;      // b has the larger magnitude
	alu_pkg::lane_t op_a;      // Larger magnitude
	alu_pkg::lane_t op_b;
	logic [ew-1:0]  exp_a;
	logic [ew-1:0]  exp_b;
	logic [ew-1:0]  exp_diff;
	logic [ew-1:0]  exp_add;
	logic [ew-1:0]  exp_sub;
	logic [sw-1:0]  sig_a;
	logic [sw-1:0]  sig_b;
	logic [sw-1:0]  sig_b_al;  // Aligned to exp_a
	logic           eff_sub;
	logic           sign_res;
	logic [sw:0]    sum;
	logic [sw:0]    diff;
	logic [sw:0]    diff_norm;
	logic [fw-1:0]  frac_add;

	////////////////////////////////////////
	// Ordering and alignment
	assign swap = (a[sp-1:0] < b[sp-1:0]);  // Exponent then fraction
	assign op_a = swap ? b : a;
	assign op_b = swap ? a : b;

	assign exp_a = op_a[sp-1 -: ew];
	assign exp_b = op_b[sp-1 -: ew];

	// Inf or NaN on either side
	assign exception = (exp_a == fp_pkg::exp_max) | (exp_b == fp_pkg::exp_max);

	// Hidden bit clear for zero exponent
	assign sig_a = {|exp_a, op_a[fw-1:0]};
	assign sig_b = {|exp_b, op_b[fw-1:0]};

	assign exp_diff = exp_a - exp_b;         // Never negative after swap
	assign sig_b_al = sig_b >> exp_diff;

	// Operation actually done on the magnitudes
	assign eff_sub = sub ^ op_a[sp] ^ op_b[sp];

	// Sign of the larger one, flipped when it was the subtrahend
	assign sign_res = (sub & swap) ? ~op_a[sp] : op_a[sp];

	////////////////////////////////////////
	// Add path
	assign sum      = {1'b0, sig_a} + {1'b0, sig_b_al};
	assign frac_add = sum[sw] ? sum[sw-1:1] : sum[fw-1:0];  // Carry shifts right
	assign exp_add  = sum[sw] ? (exp_a + exp_one) : exp_a;

	////////////////////////////////////////
	// Subtract path
	assign diff = {1'b0, sig_a} - {1'b0, sig_b_al};  // Non-negative

	fp_norm u_norm (
		.sig     (diff),
		.exp_in  (exp_a),
		.sig_out (diff_norm),
		.exp_out (exp_sub)
	);

	// Output
	always_comb
	begin
		if (exception)
			y = '0;
		else if (eff_sub)
			y = {sign_res, exp_sub, diff_norm[fw-1:0]};
		else
			y = {sign_res, exp_add, frac_add};
	end

endmodule

//--- hdl/fp_mul.sv
module fp_mul (
	input  alu_pkg::lane_t a,
	input  alu_pkg::lane_t b,
	output alu_pkg::lane_t y,
	output logic           exception,
	output logic           overflow,
	output logic           underflow
);

	localparam int sp        = fp_pkg::fp_sign_pos;
	localparam int ew        = fp_pkg::exp_width;
	localparam int fw        = fp_pkg::frac_width;
	localparam int sw        = fp_pkg::sig_width;
	localparam int prod_w    = 2 * sw;          // 48-bit product
	localparam int guard_pos = prod_w - 2 - fw; // First bit below the mantissa
	localparam int exp_ext_w = ew + 2;          // Room for carry and sign

	logic                 sign;
	logic [ew-1:0]        exp_a;
	logic [ew-1:0]        exp_b;
	logic [sw-1:0]        sig_a;
	logic [sw-1:0]        sig_b;
	logic [prod_w-1:0]    product;
	logic [prod_w-1:0]    prod_norm;
	logic                 norm;       // Product already in [2,4)
	logic                 round_up;
	logic                 prod_zero;
	logic [fw-1:0]        mant;
	logic [exp_ext_w-1:0] exp_res;    // Two's complement
	logic                 exp_ovf;
	logic                 exp_unf;

	assign sign  = a[sp] ^ b[sp];
	assign exp_a = a[sp-1 -: ew];
	assign exp_b = b[sp-1 -: ew];

	assign exception = (exp_a == fp_pkg::exp_max) | (exp_b == fp_pkg::exp_max);

	assign sig_a = {|exp_a, a[fw-1:0]};
	assign sig_b = {|exp_b, b[fw-1:0]};

	////////////////////////////////////////
	// Significand product and rounding
	assign product   = {{sw{1'b0}}, sig_a} * {{sw{1'b0}}, sig_b};
	assign prod_zero = ~|product;
	assign norm      = product[prod_w-1];
	assign prod_norm = norm ? product : (product << 1);  // Top bit is the hidden one

	// Guard set and sticky set
	assign round_up = prod_norm[guard_pos] & |prod_norm[guard_pos-1:0];
	assign mant     = prod_norm[prod_w-2 -: fw] + {{(fw-1){1'b0}}, round_up};

	// Biased sum, minus one bias, plus normalize bit
	assign exp_res = {2'b00, exp_a} + {2'b00, exp_b} - {2'b00, fp_pkg::exp_bias}
		+ {{(exp_ext_w-1){1'b0}}, norm};
	assign exp_ovf = ~exp_res[exp_ext_w-1] & exp_res[exp_ext_w-2];  // 256 and up
	assign exp_unf = exp_res[exp_ext_w-1];                          // Negative

	// Priority exception, zero, overflow, underflow
	always_comb
	begin
		overflow  = 1'b0;
		underflow = 1'b0;
		if (exception)
			y = '0;
		else if (prod_zero)
			y = {sign, {sp{1'b0}}};
		else if (exp_ovf)
		begin
			y        = {sign, fp_pkg::exp_max, {fw{1'b0}}};  // Signed infinity
			overflow = 1'b1;
		end
		else if (exp_unf)
		begin
			y         = {sign, {sp{1'b0}}};
			underflow = 1'b1;
		end
		else
			y = {sign, exp_res[ew-1:0], mant};
	end

endmodule

//--- hdl/fp_trunc.sv
module fp_trunc (
	input  alu_pkg::lane_t a,
	output alu_pkg::lane_t y
);

	localparam int sp = fp_pkg::fp_sign_pos;
	localparam int ew = fp_pkg::exp_width;
	localparam int fw = fp_pkg::frac_width;

	logic [ew-1:0] exp_a;
	logic [ew-1:0] int_bits;   // Fraction bits above the binary point
	logic [fw-1:0] keep_mask;

	assign exp_a    = a[sp-1 -: ew];
	assign int_bits = exp_a - fp_pkg::exp_bias;  // Only meaningful at or above bias

	// Mask of fraction bits that stay
	always_comb
	begin
		if (exp_a < fp_pkg::exp_bias)
			keep_mask = '0;                          // Magnitude below one
		else if (int'(int_bits) >= fw)
			keep_mask = '1;                          // Already integral
		else
			keep_mask = ~({fw{1'b1}} >> int_bits);   // Top int_bits survive
	end

	// Sign and exponent pass through
	assign y = {a[sp -: ew+1], a[fw-1:0] & keep_mask};

endmodule

//--- hdl/alu_lane.sv
module alu_lane (
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::lane_t   a,
	input  alu_pkg::lane_t   b,
	output alu_pkg::lane_t   y,
	output logic             exception,
	output logic             overflow,
	output logic             underflow
);

	localparam int w = alu_pkg::lane_width;

	// Float unit results
	alu_pkg::lane_t add_sub_y;
	alu_pkg::lane_t mul_y;
	alu_pkg::lane_t trunc_y;
	logic           add_sub_exc;
	logic           mul_exc;
	logic           mul_ovf;
	logic           mul_unf;
	logic           sub;

	// Integer results
	logic [w:0]     int_sum;   // Carry in top bit
	alu_pkg::lane_t abs_diff;
	logic [2*w-1:0] int_prod;  // Full unsigned product

	////////////////////////////////////////
	// Integer datapath
	assign int_sum  = {1'b0, a} + {1'b0, b};
	assign abs_diff = (a > b) ? (a - b) : (b - a);  // Larger minus smaller
	assign int_prod = {{w{1'b0}}, a} * {{w{1'b0}}, b};

	////////////////////////////////////////
	// Float units
	assign sub = (op == alu_pkg::op_fsub);  // Add unit shared by ops 0 and 3

	fp_add_sub u_add_sub (
		.a         (a),
		.b         (b),
		.sub       (sub),
		.y         (add_sub_y),
		.exception (add_sub_exc)
	);

	fp_mul u_mul (
		.a         (a),
		.b         (b),
		.y         (mul_y),
		.exception (mul_exc),
		.overflow  (mul_ovf),
		.underflow (mul_unf)
	);

	fp_trunc u_trunc (
		.a (a),
		.y (trunc_y)
	);

	// Result and flag select
	always_comb
	begin
		y         = '0;
		exception = 1'b0;
		overflow  = 1'b0;
		underflow = 1'b0;
		case (op)
			alu_pkg::op_fadd,
			alu_pkg::op_fsub:
			begin
				y         = add_sub_y;
				exception = add_sub_exc;
			end
			alu_pkg::op_fmul:
			begin
				y         = mul_y;
				exception = mul_exc;
				overflow  = mul_ovf;  // Only op with under/overflow
				underflow = mul_unf;
			end
			alu_pkg::op_or:       y = a | b;
			alu_pkg::op_and:      y = a & b;
			alu_pkg::op_xor:      y = a ^ b;
			alu_pkg::op_shl:      y = a << 1;
			alu_pkg::op_shr:      y = a >> 1;  // Logical, zero fill
			alu_pkg::op_ftrunc:   y = trunc_y;
			alu_pkg::op_not:      y = ~a;
			alu_pkg::op_iadd:
			begin
				y        = int_sum[w-1:0];
				overflow = int_sum[w];  // Carry out
			end
			alu_pkg::op_iabsdiff: y = abs_diff;
			alu_pkg::op_imul_hi:  y = int_prod[2*w-1:w];
			alu_pkg::op_imul_lo:  y = int_prod[w-1:0];
			alu_pkg::op_fdiv_rsvd,
			alu_pkg::op_nop:      y = '0;  // Unused codes
			default:              y = '0;
		endcase
	end

endmodule

//--- hdl/simd_alu_top.sv
module simd_alu_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  alu_pkg::alu_op_e op,
	input  alu_pkg::vec_t    a,
	input  alu_pkg::vec_t    b,
	output logic             out_valid,
	output alu_pkg::vec_t    result,
	output alu_pkg::flags_t  exception,
	output alu_pkg::flags_t  overflow,
	output alu_pkg::flags_t  underflow
);

	// Combinational lane outputs, packed
	alu_pkg::vec_t   lane_y;
	alu_pkg::flags_t lane_exc;
	alu_pkg::flags_t lane_ovf;
	alu_pkg::flags_t lane_unf;

	////////////////////////////////////////
	// Lanes, all on the same opcode
	for (genvar i = 0; i < alu_pkg::num_lanes; i++)
	begin : g_lane
		alu_lane u_lane (
			.op        (op),
			.a         (a[i*alu_pkg::lane_width +: alu_pkg::lane_width]),
			.b         (b[i*alu_pkg::lane_width +: alu_pkg::lane_width]),
			.y         (lane_y[i*alu_pkg::lane_width +: alu_pkg::lane_width]),
			.exception (lane_exc[i]),
			.overflow  (lane_ovf[i]),
			.underflow (lane_unf[i])
		);
	end

	////////////////////////////////////////
	// Output stage, one cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			result    <= '0;
			exception <= '0;
			overflow  <= '0;
			underflow <= '0;
		end
		else
		begin
			out_valid <= in_valid;  // Follows input by one edge
			if (in_valid)           // Otherwise hold last outcome
			begin
				result    <= lane_y;
				exception <= lane_exc;
				overflow  <= lane_ovf;
				underflow <= lane_unf;
			end
		end
	end

endmodule

//--- tb/tb_simd_alu.sv
module tb_simd_alu;

	localparam int num_entries = 9;
	localparam int num_rand    = 40;
	localparam int lw          = alu_pkg::lane_width;

	logic             clk;
	logic             rst_n;
	logic             in_valid;
	alu_pkg::alu_op_e op;
	alu_pkg::vec_t    a;
	alu_pkg::vec_t    b;
	logic             out_valid;
	alu_pkg::vec_t    result;
	alu_pkg::flags_t  exception;
	alu_pkg::flags_t  overflow;
	alu_pkg::flags_t  underflow;

	// Stimulus table with one entry per index
	alu_pkg::alu_op_e t_op[$];
	alu_pkg::vec_t    t_a[$];
	alu_pkg::vec_t    t_b[$];
	alu_pkg::vec_t    t_res[$];
	alu_pkg::flags_t  t_exc[$];
	alu_pkg::flags_t  t_ovf[$];
	alu_pkg::flags_t  t_unf[$];

	// Expected outcome of the item in the output stage
	alu_pkg::vec_t    p_res[$];
	alu_pkg::flags_t  p_exc[$];
	alu_pkg::flags_t  p_ovf[$];
	alu_pkg::flags_t  p_unf[$];
	string            p_name[$];

	alu_pkg::vec_t    last_res;     // What the output stage should hold
	int               pass_cnt;
	int               fail_cnt;
	bit               test_bad;
	logic [31:0]      lfsr_state;

	simd_alu_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.exception (exception),
		.overflow  (overflow),
		.underflow (underflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog
	initial
	begin
		#((num_entries + num_rand + 20) * 20 * 4);
		$display("Timeout: the run did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////
	// Compare tasks
	task automatic check_result(input alu_pkg::vec_t got, input alu_pkg::vec_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED @%0t %s result got %h expected %h", $time, what, got, exp);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_flags(input alu_pkg::flags_t got, input alu_pkg::flags_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED @%0t %s got %b expected %b", $time, what, got, exp);
			test_bad = 1'b1;
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic alu_pkg::lane_t draw_word();
		alu_pkg::lane_t w;
		logic           fb;
		for (int i = 0; i < lw; i++)
		begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			w[i]       = fb;  // One step per bit
		end
		return w;
	endfunction

	// Integer and logic rules per lane
	function automatic alu_pkg::lane_t int_model(input alu_pkg::alu_op_e o,
		input alu_pkg::lane_t x, input alu_pkg::lane_t y);
		logic [2*lw-1:0] p;
		p = {{lw{1'b0}}, x} * {{lw{1'b0}}, y};
		case (o)
			alu_pkg::op_or:       return x | y;
			alu_pkg::op_and:      return x & y;
			alu_pkg::op_xor:      return x ^ y;
			alu_pkg::op_shl:      return {x[lw-2:0], 1'b0};
			alu_pkg::op_shr:      return {1'b0, x[lw-1:1]};
			alu_pkg::op_not:      return ~x;
			alu_pkg::op_iadd:     return x + y;   // Wraps
			alu_pkg::op_iabsdiff: return (x >= y) ? x - y : y - x;
			alu_pkg::op_imul_hi:  return p[2*lw-1:lw];
			alu_pkg::op_imul_lo:  return p[lw-1:0];
			default:              return '0;
		endcase
	endfunction

	task automatic add_entry(input alu_pkg::alu_op_e o, input alu_pkg::vec_t x,
		input alu_pkg::vec_t y, input alu_pkg::vec_t r, input alu_pkg::flags_t e,
		input alu_pkg::flags_t v, input alu_pkg::flags_t u);
		t_op.push_back(o);
		t_a.push_back(x);
		t_b.push_back(y);
		t_res.push_back(r);
		t_exc.push_back(e);
		t_ovf.push_back(v);
		t_unf.push_back(u);
	endtask

	////////////////////////////////////////
	// Hand-derived entries with lane 3 on the left
	task automatic load_table();
		// 0+0, inf+1, 3+(-1), 1+2
		add_entry(alu_pkg::op_fadd, {32'h0, 32'h7F800000, 32'h40400000, 32'h3F800000},
			{32'h0, 32'h3F800000, 32'hBF800000, 32'h40000000},
			{32'h0, 32'h0, 32'h40000000, 32'h40400000}, 4'b0100, 4'b0000, 4'b0000);
		// 2-(-inf), 2-2, 1-3, 3-1
		add_entry(alu_pkg::op_fsub, {32'h40000000, 32'h40000000, 32'h3F800000, 32'h40400000},
			{32'hFF800000, 32'h40000000, 32'h40400000, 32'h3F800000},
			{32'h0, 32'h0, 32'hC0000000, 32'h40000000}, 4'b1000, 4'b0000, 4'b0000);
		// -tiny*tiny, big*big, -2*4, 1.5*2
		add_entry(alu_pkg::op_fmul, {32'h80800000, 32'h7F000000, 32'hC0000000, 32'h3FC00000},
			{32'h00800000, 32'h7F000000, 32'h40800000, 32'h40000000},
			{32'h80000000, 32'h7F800000, 32'hC1000000, 32'h40400000},
			4'b0000, 4'b0100, 4'b1000);
		// -1*-1, 2*2, 0*0, inf*1
		add_entry(alu_pkg::op_fmul, {32'hBF800000, 32'h40000000, 32'h0, 32'h7F800000},
			{32'hBF800000, 32'h40000000, 32'h0, 32'h3F800000},
			{32'h3F800000, 32'h40800000, 32'h0, 32'h0}, 4'b0001, 4'b0000, 4'b0000);
		// 1.5, 1e9, -0.5, 2.75
		add_entry(alu_pkg::op_ftrunc, {32'h3FC00000, 32'h4E6E6B28, 32'hBF000000, 32'h40300000},
			'0, {32'h3F800000, 32'h4E6E6B28, 32'hBF000000, 32'h40000000},
			4'b0000, 4'b0000, 4'b0000);
		add_entry(alu_pkg::op_fdiv_rsvd, {4{32'h3F800000}}, {4{32'h40000000}}, '0,
			4'b0000, 4'b0000, 4'b0000);
		add_entry(alu_pkg::op_nop, {4{32'hFFFFFFFF}}, {4{32'h7F800000}}, '0,
			4'b0000, 4'b0000, 4'b0000);
		// Carry out on lanes 0 and 2
		add_entry(alu_pkg::op_iadd, {32'h7, 32'h80000000, 32'h1, 32'hFFFFFFFF},
			{32'h8, 32'h80000000, 32'h2, 32'h1},
			{32'hF, 32'h0, 32'h3, 32'h0}, 4'b0000, 4'b0101, 4'b0000);
		add_entry(alu_pkg::op_imul_hi, {32'h0, 32'h10000, 32'hFFFFFFFF, 32'h2},
			{32'h5, 32'h10000, 32'hFFFFFFFF, 32'h3},
			{32'h0, 32'h1, 32'hFFFFFFFE, 32'h0}, 4'b0000, 4'b0000, 4'b0000);
	endtask

	// Check the item leaving the output stage at the falling edge
	task automatic retire();
		if (p_res.size() != 0)
		begin
			test_bad = 1'b0;
			if (out_valid !== 1'b1)
			begin
				$display("CHECK FAILED @%0t %s out_valid low when a result was due",
					$time, p_name[0]);
				test_bad = 1'b1;
			end
			check_result(result, p_res[0], p_name[0]);
			check_flags(exception, p_exc[0], {p_name[0], " exception"});
			check_flags(overflow, p_ovf[0], {p_name[0], " overflow"});
			check_flags(underflow, p_unf[0], {p_name[0], " underflow"});
			$display("%s %s", p_name[0], test_bad ? "FAIL" : "ok");
			if (test_bad)
				fail_cnt++;
			else
				pass_cnt++;
			last_res = p_res.pop_front();
			void'(p_exc.pop_front());
			void'(p_ovf.pop_front());
			void'(p_unf.pop_front());
			void'(p_name.pop_front());
		end
	endtask

	task automatic issue(input alu_pkg::alu_op_e o, input alu_pkg::vec_t x,
		input alu_pkg::vec_t y, input alu_pkg::vec_t r, input alu_pkg::flags_t e,
		input alu_pkg::flags_t v, input alu_pkg::flags_t u, input string name);
		in_valid = 1'b1;
		op       = o;
		a        = x;
		b        = y;
		p_res.push_back(r);
		p_exc.push_back(e);
		p_ovf.push_back(v);
		p_unf.push_back(u);
		p_name.push_back(name);
	endtask

	////////////////////////////////////////
	// Main sequence
	initial
	begin
		alu_pkg::alu_op_e rand_ops[10];
		alu_pkg::alu_op_e ro;
		alu_pkg::vec_t    ra;
		alu_pkg::vec_t    rb;
		alu_pkg::vec_t    rr;
		alu_pkg::flags_t  rv;
		alu_pkg::lane_t   wa;
		alu_pkg::lane_t   wb;

		rand_ops = '{alu_pkg::op_or, alu_pkg::op_and, alu_pkg::op_xor, alu_pkg::op_shl,
			alu_pkg::op_shr, alu_pkg::op_not, alu_pkg::op_iadd, alu_pkg::op_iabsdiff,
			alu_pkg::op_imul_hi, alu_pkg::op_imul_lo};
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		op         = alu_pkg::op_nop;
		a          = '0;
		b          = '0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		lfsr_state = 32'h9138_e599;
		last_res   = '0;
		load_table();

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Outputs cleared by reset
		@(negedge clk);
		test_bad = 1'b0;
		if (out_valid !== 1'b0)
		begin
			$display("CHECK FAILED @%0t out_valid high after reset", $time);
			test_bad = 1'b1;
		end
		check_result(result, '0, "reset");
		check_flags(exception | overflow | underflow, '0, "reset flags");
		$display("reset %s", test_bad ? "FAIL" : "ok");
		if (test_bad)
			fail_cnt++;
		else
			pass_cnt++;

		// Table back to back
		for (int i = 0; i < t_op.size(); i++)
		begin
			issue(t_op[i], t_a[i], t_b[i], t_res[i], t_exc[i], t_ovf[i], t_unf[i],
				$sformatf("table %0d", i));
			@(negedge clk);
			retire();
		end

		// Idle cycle where valid drops and result holds
		in_valid = 1'b0;
		a        = '1;
		#1;
		test_bad = 1'b0;
		if (out_valid !== 1'b1)  // Registered, so no change before the edge
		begin
			$display("CHECK FAILED @%0t out_valid dropped before the clock edge", $time);
			test_bad = 1'b1;
		end
		check_result(result, last_res, "idle before edge");
		@(negedge clk);
		if (out_valid !== 1'b0)
		begin
			$display("CHECK FAILED @%0t out_valid stayed high with no input", $time);
			test_bad = 1'b1;
		end
		check_result(result, last_res, "idle hold");
		$display("idle hold %s", test_bad ? "FAIL" : "ok");
		if (test_bad)
			fail_cnt++;
		else
			pass_cnt++;

		////////////////////////////////////////
		// Random integer and logic phase
		for (int n = 0; n < num_rand; n++)
		begin
			ro = rand_ops[n % 10];  // Every op four times
			rv = '0;
			for (int l = 0; l < alu_pkg::num_lanes; l++)
			begin
				wa = draw_word();
				wb = draw_word();
				ra[l*lw +: lw] = wa;
				rb[l*lw +: lw] = wb;
				rr[l*lw +: lw] = int_model(ro, wa, wb);
				if (ro == alu_pkg::op_iadd)
					rv[l] = (wb > ~wa);  // Carry when b exceeds the room above a
			end
			issue(ro, ra, rb, rr, '0, rv, '0, $sformatf("random %0d %s", n, ro.name()));
			@(negedge clk);
			retire();
		end
		in_valid = 1'b0;
		@(negedge clk);

		$display("passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- build.f
hdl/alu_pkg.sv
hdl/fp_pkg.sv
hdl/fp_norm.sv
hdl/fp_add_sub.sv
hdl/fp_mul.sv
hdl/fp_trunc.sv
hdl/alu_lane.sv
hdl/simd_alu_top.sv
tb/tb_simd_alu.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_simd_alu -f build.f
	./obj_dir/Vtb_simd_alu > sim.log
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
